// ==== rtl/scanner_pkg.sv ====
package scanner_pkg;

    //////////////////////////////////////////////////
    // widths and line geometry

    localparam int adc_w            = 12;   // bits per adc sample
    localparam int slot_w           = 16;   // packed slot, sample zero-extended
    localparam int beat_w           = 128;  // one memory beat
    localparam int samples_per_beat = 8;
    localparam int pixels_per_line  = 32;   // 4 beats per line
    localparam int pix_w            = $clog2(pixels_per_line);
    localparam int adr_w            = 28;   // in 16-byte words
    localparam int lamp_cnt_w       = 16;
    localparam int delay_w          = 24;   // free-run line period
    localparam int div_w            = 16;   // encoder decimation
    localparam int pos_w            = 32;
    localparam int done_w           = 16;   // ring wrap counters
    localparam int num_colors       = 3;
    localparam int chan_w           = $clog2(num_colors);

    localparam logic [adc_w-1:0] pattern_const = 12'ha5a;

    //////////////////////////////////////////////////
    // encodings

    // colour code doubles as the channel index and the lrgb bit
    typedef enum logic [1:0] {
        color_red   = 2'd0,
        color_green = 2'd1,
        color_blue  = 2'd2
    } color_e;

    typedef enum logic [1:0] {
        mode_off      = 2'd0,
        mode_free_run = 2'd1,
        mode_encoder  = 2'd2
    } scan_mode_e;

    typedef enum logic [1:0] {
        test_adc   = 2'd0,  // raw sample
        test_ramp  = 2'd1,  // pixel index within the line
        test_const = 2'd2   // pattern_const
    } test_mode_e;

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_start   = 2'd1,
        st_capture = 2'd2
    } line_state_e;

endpackage

// ==== rtl/quad_encoder.sv ====
module quad_encoder import scanner_pkg::*;
(
    input  logic                    w_bus_clk,
    input  logic                    w_adc_rst,
    input  logic                    enc_a,
    input  logic                    enc_b,
    input  logic [div_w-1:0]        pulses_cnt_div,
    output logic signed [pos_w-1:0] position,
    output logic                    line_trig
);

    logic [2:0]       a_pipe;   // [0] meta, [1] synced, [2] previous
    logic [2:0]       b_pipe;
    logic             step;
    logic             step_up;
    logic [div_w-1:0] div_cnt;
    logic [div_w-1:0] div_lim;

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            a_pipe <= '0;
            b_pipe <= '0;
        end
        else
        begin
            a_pipe <= {a_pipe[1:0], enc_a};
            b_pipe <= {b_pipe[1:0], enc_b};
        end
    end

    // exactly one input moved, so a legal gray step
    assign step    = (a_pipe[1] ^ a_pipe[2]) ^ (b_pipe[1] ^ b_pipe[2]);
    assign step_up = a_pipe[1] ^ b_pipe[2];     // a leads b
    assign div_lim = (pulses_cnt_div == '0) ? div_w'(1) : pulses_cnt_div;

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            position  <= '0;
            div_cnt   <= '0;
            line_trig <= 1'b0;
        end
        else
        begin
            line_trig <= 1'b0;
            if (step)
            begin
                position <= step_up ? position + 1'b1 : position - 1'b1;
                if (div_cnt >= div_lim - 1'b1)
                begin
                    div_cnt   <= '0;
                    line_trig <= 1'b1;
                end
                else
                    div_cnt <= div_cnt + 1'b1;  // both directions count
            end
        end
    end

endmodule

// ==== rtl/cis_line_ctrl.sv ====
module cis_line_ctrl import scanner_pkg::*;
(
    input  logic                  w_bus_clk,
    input  logic                  w_adc_rst,
    input  scan_mode_e            scan_mode,
    input  logic [delay_w-1:0]    lines_delay,
    input  logic                  line_trig,
    input  logic [lamp_cnt_w-1:0] r_on_cnt,
    input  logic [lamp_cnt_w-1:0] g_on_cnt,
    input  logic [lamp_cnt_w-1:0] b_on_cnt,
    output logic                  si,
    output logic [2:0]            lrgb,         // active low, bit = colour code
    output logic                  sample_en,
    output logic [pix_w-1:0]      pix_index,
    output color_e                line_color
);

    line_state_e           state;
    color_e                lamp_color;
    logic [delay_w-1:0]    delay_cnt;
    logic                  period_tick;
    logic                  start;
    logic [lamp_cnt_w-1:0] on_time;
    logic [lamp_cnt_w-1:0] lamp_cnt;

    //////////////////////////////////////////////////
    // start source

    assign period_tick = ({1'b0, delay_cnt} + 1'b1) >= {1'b0, lines_delay};

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst || scan_mode != mode_free_run)
            delay_cnt <= '0;
        else if (period_tick)
            delay_cnt <= '0;
        else
            delay_cnt <= delay_cnt + 1'b1;
    end

    always_comb
    begin
        case (scan_mode)
            mode_free_run: start = period_tick;
            mode_encoder:  start = line_trig;
            default:       start = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // line sequencing

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            state      <= st_idle;
            pix_index  <= '0;
            line_color <= color_red;
        end
        else
        begin
            case (state)
                st_idle:
                    if (start)
                        state <= st_start;  // starts elsewhere are dropped
                st_start:
                    state <= st_capture;
                st_capture:
                begin
                    pix_index <= pix_index + 1'b1;
                    if (pix_index == pix_w'(pixels_per_line - 1))
                    begin
                        state <= st_idle;
                        case (line_color)
                            color_red:   line_color <= color_green;
                            color_green: line_color <= color_blue;
                            default:     line_color <= color_red;
                        endcase
                    end
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    assign si        = (state == st_start);
    assign sample_en = (state == st_capture);

    //////////////////////////////////////////////////
    // lamp timing

    always_comb
    begin
        case (line_color)
            color_red:   on_time = r_on_cnt;
            color_green: on_time = g_on_cnt;
            default:     on_time = b_on_cnt;
        endcase
    end

    // loaded with the start so the lamp lights together with si
    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            lamp_cnt   <= '0;
            lamp_color <= color_red;
        end
        else if (state == st_idle && start)
        begin
            lamp_cnt   <= on_time;
            lamp_color <= line_color;
        end
        else if (lamp_cnt != '0)
            lamp_cnt <= lamp_cnt - 1'b1;
    end

    always_comb
    begin
        for (int i = 0; i < num_colors; i++)
            lrgb[i] = !((lamp_cnt != '0) && (lamp_color == color_e'(i)));
    end

endmodule

// ==== rtl/pixel_packer.sv ====
module pixel_packer import scanner_pkg::*;
(
    input  logic              w_bus_clk,
    input  logic              w_adc_rst,
    input  logic [adc_w-1:0]  adc_data,
    input  test_mode_e        test_mode,
    input  logic              sample_en,
    input  logic [pix_w-1:0]  pix_index,
    input  color_e            line_color,
    output logic              beat_valid,
    output logic [beat_w-1:0] beat_data,
    output color_e            beat_color
);

    logic [adc_w-1:0] sample;
    logic             last_slot;

    always_comb
    begin
        case (test_mode)
            test_ramp:  sample = adc_w'(pix_index);
            test_const: sample = pattern_const;
            default:    sample = adc_data;
        endcase
    end

    assign last_slot = (pix_index[$clog2(samples_per_beat)-1:0] ==
                        samples_per_beat - 1);

    // new sample enters at the top, first sample ends in the low slot
    always_ff @(posedge w_bus_clk)
    begin
        if (sample_en)
            beat_data <= {slot_w'(sample), beat_data[beat_w-1:slot_w]};
    end

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            beat_valid <= 1'b0;
            beat_color <= color_red;
        end
        else
        begin
            beat_valid <= sample_en && last_slot;
            if (sample_en && last_slot)
                beat_color <= line_color;   // tag follows the beat
        end
    end

endmodule

// ==== rtl/dma_channel_writer.sv ====
module dma_channel_writer import scanner_pkg::*;
(
    input  logic              w_bus_clk,
    input  logic              w_adc_rst,
    input  logic              dma_on,
    input  logic [adr_w-1:0]  base_adr,
    input  logic [adr_w-1:0]  dma_buf_size,
    input  logic              beat_valid,
    input  logic [beat_w-1:0] beat_data,
    input  logic              grant,
    output logic              req,
    output logic [adr_w-1:0]  adr,
    output logic [beat_w-1:0] data,
    output logic              ovr,
    output logic [done_w-1:0] done_cnt
);

    logic [adr_w-1:0] ofs;      // k mod buffer size
    logic [adr_w-1:0] ofs_inc;
    logic             ofs_wrap;
    logic             full;
    logic             last;     // held beat closes the ring
    logic             take;

    assign ofs_inc  = ofs + 1'b1;
    assign ofs_wrap = (ofs_inc >= dma_buf_size);
    assign take     = beat_valid && (!full || grant);
    assign req      = full;

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst || !dma_on)
        begin
            full     <= 1'b0;
            ofs      <= '0;
            done_cnt <= '0;
        end
        else
        begin
            if (take)
            begin
                full <= 1'b1;
                ofs  <= ofs_wrap ? '0 : ofs_inc;
            end
            else if (grant)
                full <= 1'b0;
            if (grant && last)
                done_cnt <= done_cnt + 1'b1;
        end
    end

    // sticky, cleared by reset only
    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
            ovr <= 1'b0;
        else if (dma_on && beat_valid && full && !grant)
            ovr <= 1'b1;
    end

    always_ff @(posedge w_bus_clk)
    begin
        if (take)
        begin
            data <= beat_data;
            adr  <= base_adr + ofs;
            last <= ofs_wrap;
        end
    end

endmodule

// ==== rtl/sdram_write_mux.sv ====
module sdram_write_mux import scanner_pkg::*;
(
    input  logic                  w_bus_clk,
    input  logic                  w_adc_rst,
    input  logic [num_colors-1:0] req,
    input  logic [adr_w-1:0]      adr_in  [num_colors],
    input  logic [beat_w-1:0]     data_in [num_colors],
    input  logic                  sdram_waitrequest,
    output logic [num_colors-1:0] grant,
    output logic                  sdram_write,
    output logic [adr_w-1:0]      sdram_address,
    output logic [beat_w-1:0]     sdram_writedata
);

    logic [chan_w-1:0] sel;
    logic [chan_w-1:0] pick;

    // lowest channel number wins
    always_comb
    begin
        pick = '0;
        for (int i = num_colors - 1; i >= 0; i--)
            if (req[i])
                pick = chan_w'(i);
    end

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            sdram_write <= 1'b0;
            sel         <= '0;
        end
        else if (!sdram_write)
        begin
            if (|req)
            begin
                sdram_write <= 1'b1;
                sel         <= pick;    // locked until accepted
            end
        end
        else if (!sdram_waitrequest)
            sdram_write <= 1'b0;
    end

    // writer holds its beat until grant, so the port stays steady
    assign sdram_address   = adr_in[sel];
    assign sdram_writedata = data_in[sel];

    always_comb
    begin
        grant      = '0;
        grant[sel] = sdram_write && !sdram_waitrequest;
    end

endmodule

// ==== rtl/scanner_top.sv ====
module scanner_top import scanner_pkg::*;
(
    input  logic                    w_bus_clk,
    input  logic                    w_adc_rst,
    input  logic                    enc_a,
    input  logic                    enc_b,
    input  logic [adc_w-1:0]        adc_data,
    input  scan_mode_e              scan_mode,
    input  test_mode_e              test_mode,
    input  logic [delay_w-1:0]      lines_delay,
    input  logic [div_w-1:0]        pulses_cnt_div,
    input  logic [lamp_cnt_w-1:0]   r_on_cnt,
    input  logic [lamp_cnt_w-1:0]   g_on_cnt,
    input  logic [lamp_cnt_w-1:0]   b_on_cnt,
    input  logic                    dma_on,
    input  logic [adr_w-1:0]        dma_start_address,
    input  logic [adr_w-1:0]        dma_buf_size,
    input  logic                    sdram_waitrequest,
    output logic                    si,
    output logic [2:0]              lrgb,
    output logic                    sdram_write,
    output logic [adr_w-1:0]        sdram_address,
    output logic [beat_w-1:0]       sdram_writedata,
    output logic                    fifo_ovr,
    output logic [done_w-1:0]       done_cnt,
    output logic signed [pos_w-1:0] position
);

    logic                  line_trig;
    logic                  sample_en;
    logic [pix_w-1:0]      pix_index;
    color_e                line_color;
    logic                  beat_valid;
    logic [beat_w-1:0]     beat_data;
    color_e                beat_color;
    logic [num_colors-1:0] req;
    logic [num_colors-1:0] grant;
    logic [num_colors-1:0] ovr;
    logic [adr_w-1:0]      ch_adr  [num_colors];
    logic [beat_w-1:0]     ch_data [num_colors];
    logic [done_w-1:0]     ch_done [num_colors];

    quad_encoder i_quad_encoder
    (
        .w_bus_clk      ( w_bus_clk         ),
        .w_adc_rst      ( w_adc_rst         ),
        .enc_a          ( enc_a             ),
        .enc_b          ( enc_b             ),
        .pulses_cnt_div ( pulses_cnt_div    ),
        .position       ( position          ),
        .line_trig      ( line_trig         )
    );

    cis_line_ctrl i_cis_line_ctrl
    (
        .w_bus_clk      ( w_bus_clk         ),
        .w_adc_rst      ( w_adc_rst         ),
        .scan_mode      ( scan_mode         ),
        .lines_delay    ( lines_delay       ),
        .line_trig      ( line_trig         ),
        .r_on_cnt       ( r_on_cnt          ),
        .g_on_cnt       ( g_on_cnt          ),
        .b_on_cnt       ( b_on_cnt          ),
        .si             ( si                ),
        .lrgb           ( lrgb              ),
        .sample_en      ( sample_en         ),
        .pix_index      ( pix_index         ),
        .line_color     ( line_color        )
    );

    pixel_packer i_pixel_packer
    (
        .w_bus_clk      ( w_bus_clk         ),
        .w_adc_rst      ( w_adc_rst         ),
        .adc_data       ( adc_data          ),
        .test_mode      ( test_mode         ),
        .sample_en      ( sample_en         ),
        .pix_index      ( pix_index         ),
        .line_color     ( line_color        ),
        .beat_valid     ( beat_valid        ),
        .beat_data      ( beat_data         ),
        .beat_color     ( beat_color        )
    );

    //////////////////////////////////////////////////
    // one writer per colour, ring g sits g buffers above the start

    for (genvar g = 0; g < num_colors; g++)
    begin : g_writer
        dma_channel_writer i_writer
        (
            .w_bus_clk    ( w_bus_clk                                      ),
            .w_adc_rst    ( w_adc_rst                                      ),
            .dma_on       ( dma_on                                         ),
            .base_adr     ( dma_start_address + adr_w'(g) * dma_buf_size   ),
            .dma_buf_size ( dma_buf_size                                   ),
            .beat_valid   ( beat_valid && (beat_color == color_e'(g))      ),
            .beat_data    ( beat_data                                      ),
            .grant        ( grant[g]                                       ),
            .req          ( req[g]                                         ),
            .adr          ( ch_adr[g]                                      ),
            .data         ( ch_data[g]                                     ),
            .ovr          ( ovr[g]                                         ),
            .done_cnt     ( ch_done[g]                                     )
        );
    end

    sdram_write_mux i_sdram_write_mux
    (
        .w_bus_clk         ( w_bus_clk         ),
        .w_adc_rst         ( w_adc_rst         ),
        .req               ( req               ),
        .adr_in            ( ch_adr            ),
        .data_in           ( ch_data           ),
        .sdram_waitrequest ( sdram_waitrequest ),
        .grant             ( grant             ),
        .sdram_write       ( sdram_write       ),
        .sdram_address     ( sdram_address     ),
        .sdram_writedata   ( sdram_writedata   )
    );

    assign fifo_ovr = |ovr;
    assign done_cnt = ch_done[0];   // red ring only

endmodule

// ==== bench/tb_scanner.sv ====
module tb_scanner import scanner_pkg::*;
();

    localparam int max_tests = 16;
    localparam int step_gap  = 12;                // cycles between encoder steps
    localparam logic [adr_w-1:0] start_adr = 28'h0100000;

    logic                    w_bus_clk = 1'b0;
    logic                    w_adc_rst;
    logic                    enc_a, enc_b, dma_on, sdram_waitrequest;
    logic [adc_w-1:0]        adc_data;
    scan_mode_e              scan_mode;
    test_mode_e              test_mode;
    logic [delay_w-1:0]      lines_delay;
    logic [div_w-1:0]        pulses_cnt_div;
    logic [lamp_cnt_w-1:0]   on_cnt [num_colors];
    logic [adr_w-1:0]        dma_buf_size;
    logic                    si, sdram_write, fifo_ovr;
    logic [2:0]              lrgb;
    logic [adr_w-1:0]        sdram_address;
    logic [beat_w-1:0]       sdram_writedata;
    logic [done_w-1:0]       done_cnt;
    logic signed [pos_w-1:0] position;

    // trace records
    int t_mode [max_tests], t_tmode [max_tests], t_lines [max_tests], t_delay [max_tests];
    int t_on [max_tests][3], t_div [max_tests], t_buf [max_tests], t_duty [max_tests];
    int t_toggle [max_tests], t_sfirst [max_tests], t_scnt [max_tests];
    int steps[$];
    int num_tests = 0;

    logic [31:0]  seed = 32'hf7e84644;
    longint       limit = 0;
    int           errors = 0, duty = 0, si_total = 0, cap_cnt = 0, wraps = 0;
    int           k [num_colors];
    int           lamp_run [num_colors];
    int           lamp_exp [num_colors];
    int           gray_idx = 0;
    int           exp_pos = 0;
    bit           running = 0, discard = 0;
    logic [1:0]   cap_color;
    logic [127:0] acc;
    logic [129:0] exp_q[$];                      // {colour, beat}

    scanner_top i_dut
    (
        .w_bus_clk(w_bus_clk), .w_adc_rst(w_adc_rst), .enc_a(enc_a), .enc_b(enc_b),
        .adc_data(adc_data), .scan_mode(scan_mode), .test_mode(test_mode),
        .lines_delay(lines_delay), .pulses_cnt_div(pulses_cnt_div),
        .r_on_cnt(on_cnt[0]), .g_on_cnt(on_cnt[1]), .b_on_cnt(on_cnt[2]),
        .dma_on(dma_on), .dma_start_address(start_adr), .dma_buf_size(dma_buf_size),
        .sdram_waitrequest(sdram_waitrequest), .si(si), .lrgb(lrgb),
        .sdram_write(sdram_write), .sdram_address(sdram_address),
        .sdram_writedata(sdram_writedata), .fifo_ovr(fifo_ovr), .done_cnt(done_cnt),
        .position(position)
    );

    always #50 w_bus_clk = ~w_bus_clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic read_trace();
        int    fd;
        int    v;
        int    n;
        string line;
        fd = $fopen("bench/scan_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the trace file");
            errors++;
            return;
        end
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() > 0 && line.getc(0) == "T")
            begin
                n = $sscanf(line, "T %d %d %d %d %d %d %d %d %d %d %d",
                    t_mode[num_tests], t_tmode[num_tests], t_lines[num_tests],
                    t_delay[num_tests], t_on[num_tests][0], t_on[num_tests][1],
                    t_on[num_tests][2], t_div[num_tests], t_buf[num_tests],
                    t_duty[num_tests], t_toggle[num_tests]);
                if (n != 11)
                begin
                    $display("trace record %0d is incomplete", num_tests);
                    errors++;
                end
                t_sfirst[num_tests] = steps.size();
                t_scnt[num_tests]   = 0;
                num_tests++;
            end
            else if (line.len() > 0 && line.getc(0) == "S" && num_tests > 0)
            begin
                n = $sscanf(line, "S %d", v);
                steps.push_back(v);
                t_scnt[num_tests-1]++;
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // stimulus drivers

    always @(negedge w_bus_clk)
    begin
        logic [31:0] r;
        if (running)
        begin
            r = lcg_next();
            adc_data = r[27:16];
            r = lcg_next();
            sdram_waitrequest = (int'(r[31:16]) % 100) < duty;
        end
    end

    task automatic drive_steps(input int n);
        int s;
        for (s = 0; s < (n < 0 ? -n : n); s++)
        begin
            gray_idx = (gray_idx + (n < 0 ? 3 : 1)) % 4;    // a leads b going up
            enc_a = (gray_idx == 1) || (gray_idx == 2);
            enc_b = (gray_idx == 2) || (gray_idx == 3);
            exp_pos += (n < 0) ? -1 : 1;
            repeat (step_gap) @(negedge w_bus_clk);
        end
    endtask

    task automatic free_run_lines(input int n);
        int target;
        target = si_total + n;
        scan_mode = mode_free_run;
        while (si_total < target)
            @(negedge w_bus_clk);
        scan_mode = mode_off;
        repeat (40) @(negedge w_bus_clk);
    endtask

    //////////////////////////////////////////////////
    // monitor and reference model

    always @(posedge w_bus_clk)
    begin
        logic [129:0] e;
        int           c, idx;
        logic [11:0]  smp;
        logic [2:0]   lit;
        if (!w_adc_rst && running)
        begin
            if (sdram_write && !sdram_waitrequest)
            begin
                if (!dma_on)
                begin
                    $display("write accepted at %0t while dma_on is low", $time);
                    errors++;
                end
                else if (exp_q.size() == 0)
                begin
                    $display("write at %0t with no beat expected", $time);
                    errors++;
                end
                else
                begin
                    e = exp_q.pop_front();
                    c = int'(e[129:128]);
                    check_value("sdram_writedata", sdram_writedata, e[127:0]);
                    check_value("sdram_address", 128'(sdram_address),
                        128'(start_adr + c * dma_buf_size + (k[c] % dma_buf_size)));
                    k[c]++;
                    if (c == 0 && (k[0] % dma_buf_size) == 0)
                        wraps++;
                end
            end
            if (cap_cnt > 0)
            begin
                idx = pixels_per_line - cap_cnt;
                case (test_mode)
                    test_ramp:  smp = 12'(idx);
                    test_const: smp = 12'ha5a;
                    default:    smp = adc_data;
                endcase
                acc[(idx % 8) * 16 +: 16] = {4'h0, smp};
                if (idx % 8 == 7 && !discard)
                    exp_q.push_back({cap_color, acc});
                cap_cnt--;
            end
            if (si)
            begin
                cap_cnt   = pixels_per_line;
                cap_color = 2'(si_total % 3);
                lamp_exp[si_total % 3] = on_cnt[si_total % 3];
                lit = 3'b111;                   // only this line's lamp, if any
                if (on_cnt[si_total % 3] != 0)
                    lit[si_total % 3] = 1'b0;
                check_value("lrgb", 128'(lrgb), 128'(lit));
                si_total++;
            end
            if ((!lrgb[0] + !lrgb[1] + !lrgb[2]) > 1)
            begin
                $display("more than one lamp lit at %0t", $time);
                errors++;
            end
            for (int i = 0; i < num_colors; i++)
            begin
                if (!lrgb[i])
                    lamp_run[i]++;
                else if (lamp_run[i] != 0)
                begin
                    check_value("lamp on-time", 128'(lamp_run[i]), 128'(lamp_exp[i]));
                    lamp_run[i] = 0;
                end
            end
        end
    end

    task automatic run_test(input int t);
        int err0, si0, total, s;
        err0 = errors;
        test_mode    = test_mode_e'(t_tmode[t]);
        lines_delay  = t_delay[t];
        on_cnt[0]    = t_on[t][0];
        on_cnt[1]    = t_on[t][1];
        on_cnt[2]    = t_on[t][2];
        pulses_cnt_div = t_div[t];
        dma_buf_size = t_buf[t];
        duty         = t_duty[t];
        dma_on       = 1'b0;                     // ring restarts at each base
        discard      = (t_toggle[t] != 0) || (t_duty[t] >= 100);
        @(negedge w_bus_clk);
        if (t_toggle[t] != 0)
            free_run_lines(t_lines[t]);
        dma_on  = 1'b1;
        discard = (t_duty[t] >= 100);
        wraps   = 0;
        k       = '{default: 0};
        si0     = si_total;
        if (t_mode[t] == 2)
        begin
            scan_mode = mode_encoder;
            total = 0;
            for (s = 0; s < t_scnt[t]; s++)
            begin
                drive_steps(steps[t_sfirst[t] + s]);
                total += (steps[t_sfirst[t] + s] < 0) ? -steps[t_sfirst[t] + s]
                                                      : steps[t_sfirst[t] + s];
            end
            scan_mode = mode_off;
            repeat (40) @(negedge w_bus_clk);
            check_value("si pulses", 128'(si_total - si0), 128'(total / t_div[t]));
            check_value("position", 128'(position), 128'(exp_pos));
        end
        else
            free_run_lines(t_lines[t]);
        if (t_duty[t] >= 100)
        begin
            check_value("fifo_ovr", 128'(fifo_ovr), 128'(1));
            repeat (50) @(negedge w_bus_clk);
            check_value("fifo_ovr", 128'(fifo_ovr), 128'(1));
        end
        else
        begin
            while (exp_q.size() != 0 || sdram_write)
                @(negedge w_bus_clk);
            check_value("done_cnt", 128'(done_cnt), 128'(wraps));
            check_value("fifo_ovr", 128'(fifo_ovr), 128'(0));
        end
        $display("test %0d %s", t, (errors == err0) ? "passed" : "failed");
    endtask

    //////////////////////////////////////////////////
    // watchdog

    initial
    begin
        wait (limit != 0);
        #(limit);
        $display("timeout, the run did not finish in %0d time units", limit);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        int t;
        longint cyc;
        w_adc_rst = 1'b1;
        enc_a = 1'b0;
        enc_b = 1'b0;
        dma_on = 1'b0;
        sdram_waitrequest = 1'b0;
        adc_data = '0;
        scan_mode = mode_off;
        test_mode = test_adc;
        lines_delay = '0;
        pulses_cnt_div = '0;
        on_cnt = '{default: '0};
        dma_buf_size = 28'd4;
        lamp_run = '{default: 0};
        lamp_exp = '{default: 0};
        k = '{default: 0};
        read_trace();
        cyc = 200;
        for (t = 0; t < num_tests; t++)
        begin
            cyc += t_lines[t] * (t_delay[t] + 40) * (t_toggle[t] != 0 ? 2 : 1) + 300;
            for (int s = 0; s < t_scnt[t]; s++)
                cyc += ((steps[t_sfirst[t] + s] < 0) ? -steps[t_sfirst[t] + s]
                                                     : steps[t_sfirst[t] + s]) * step_gap;
        end
        limit = cyc * 2 * 100;
        repeat (8) @(negedge w_bus_clk);
        w_adc_rst = 1'b0;
        check_value("si", 128'(si), 128'(0));
        check_value("lrgb", 128'(lrgb), 128'(3'b111));
        check_value("sdram_write", 128'(sdram_write), 128'(0));
        check_value("fifo_ovr", 128'(fifo_ovr), 128'(0));
        check_value("position", 128'(position), 128'(0));
        running = 1;
        for (t = 0; t < num_tests; t++)
            run_test(t);
        $display("%0d tests run, %0d errors", num_tests, errors);
        if (errors == 0 && num_tests > 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== bench/scan_trace.txt ====
# T mode tmode lines delay r_on g_on b_on div buf_size wait_duty dma_toggle
#   mode 1 free run, 2 encoder; tmode 0 adc, 1 ramp, 2 const; duty in percent
# S n follows an encoder record: n steps up, or down when negative

# free run, ramp pattern, no waitrequest, ring of 5 wraps on red
T 1 1 6 60 10 20 30 1 5 0 0

# lamp timing with a dark green lamp
T 1 1 3 55 5 0 40 1 8 0 0

# raw adc samples under random waitrequest
T 1 0 6 50 12 7 3 1 8 30 0

# encoder driven lines, divisor 4
T 2 1 0 60 8 8 8 4 16 0 0
S 20
S -8
S 12

# encoder going backwards only
T 2 0 0 60 4 6 9 4 6 15 0
S -16

# constant pattern, dma off for the first lines then back on
T 1 2 3 45 6 6 6 1 4 10 1

# waitrequest stuck high, overflow must latch
T 1 0 2 60 6 6 6 1 8 100 0

// ==== vlog.f ====
rtl/scanner_pkg.sv
rtl/quad_encoder.sv
rtl/cis_line_ctrl.sv
rtl/pixel_packer.sv
rtl/dma_channel_writer.sv
rtl/sdram_write_mux.sv
rtl/scanner_top.sv
bench/tb_scanner.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_scanner -o Vtb_scanner

run: build
	./obj_dir/Vtb_scanner | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "no result in log"; exit 1)

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module tb_scanner
	verilator --lint-only -Wall rtl/scanner_pkg.sv rtl/quad_encoder.sv \
		rtl/cis_line_ctrl.sv rtl/pixel_packer.sv rtl/dma_channel_writer.sv \
		rtl/sdram_write_mux.sv rtl/scanner_top.sv --top-module scanner_top

clean:
	rm -rf obj_dir $(LOG)
